//--- mipsApb.f
common/mipsPkg.sv
cpu/grf.sv
cpu/cpuCtrl.sv
cpu/cpu.sv
hdl/apbBridge.sv
hdl/apbTimer.sv
hdl/apbRam.sv
hdl/progMem.sv
hdl/mipsSoc.sv
tb/tbMipsSoc.sv

//--- Bender.yml
package:
  name: mipsApb

sources:
  - common/mipsPkg.sv
  - cpu/grf.sv
  - cpu/cpuCtrl.sv
  - cpu/cpu.sv
  - hdl/apbBridge.sv
  - hdl/apbTimer.sv
  - hdl/apbRam.sv
  - hdl/progMem.sv
  - hdl/mipsSoc.sv
  - target: test
    files:
      - tb/tbMipsSoc.sv

//--- tb/socStim.txt
# P <word index hex> <instruction hex>, word 0 is 0x3000, word 060 is 0x4180
# E <test name> <register decimal> <expected value hex>, in writeback order
P 000 34011234
P 001 3C028000
P 002 3442FFFF
P 003 00421821
P 004 00222023
P 005 AC030010
P 006 AC040024
P 007 8C050010
P 008 8C060024
P 009 10A30001
P 00A 3407DEAD
P 00B 34070011
P 00C 08000C0E
P 00D 3408DEAD
P 00E 34080022
P 00F 340A7F00
P 010 340B0014
P 011 AD4B0004
P 012 340C0002
P 013 AD4C0000
P 014 8D4D0004
P 015 8D4E0000
P 016 340F0003
P 017 AD4F0000
P 018 1120FFFF
P 019 34100055
P 01A 1000FFFF
P 060 3409BEEF
P 061 AD400000
P 062 42000018
E aluOps 1 00001234
E aluOps 2 80000000
E aluOps 2 8000FFFF
E aluOps 3 0001FFFE
E aluOps 4 7FFF1235
E memRoundTrip 5 0001FFFE
E memRoundTrip 6 7FFF1235
E ctrlFlow 7 00000011
E ctrlFlow 8 00000022
E timerRegs 10 00007F00
E timerRegs 11 00000014
E timerRegs 12 00000002
E timerRegs 13 00000014
E timerRegs 14 00000002
E timerIrq 15 00000003
E timerIrq 9 0000BEEF
E timerIrq 16 00000055

//--- tb/tbMipsSoc.sv
`timescale 1ns/100ps

module tbMipsSoc;
    localparam int          RESET_CYCLES = 10;
    localparam int          MAX_EXP      = 64;
    localparam logic [31:0] BOOT_PC      = 32'h0000_3000;
    // Preset written by the interrupt part of the program
    localparam int          TIMER_PRESET = 20;

    logic        clk;
    logic        rst;
    logic        progWe;
    logic [9:0]  progAddr;
    logic [31:0] progData;
    logic [31:0] PC;
    logic        wbEn;
    logic [4:0]  wbAddr;
    logic [31:0] wbData;

    // Program image and expected writeback trace
    logic [9:0]       progIdx  [1024];
    logic [31:0]      progWord [1024];
    logic [8*16-1:0]  expName  [MAX_EXP];
    logic [4:0]       expReg   [MAX_EXP];
    logic [31:0]      expValue [MAX_EXP];
    int progCount;
    int expCount;
    int expIdx;
    int errors;
    int checks;
    int testsPassed;
    int testsFailed;
    bit traceOn;

    mipsSoc mipsSoc_i (
        .clk(clk), .rst(rst), .progWe(progWe), .progAddr(progAddr), .progData(progData),
        .PC(PC), .wbEn(wbEn), .wbAddr(wbAddr), .wbData(wbData)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    task automatic checkValue(input logic [8*16-1:0] name, input logic [31:0] expected,
                              input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("[ERROR] %0s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic reportTest(input logic [8*16-1:0] name, input int newErrors);
        if (newErrors == 0) begin
            testsPassed++;
            $display("[PASS] %0s", name);
        end else begin
            testsFailed++;
            $display("[FAIL] %0s with %0d mismatches", name, newErrors);
        end
    endtask

    // P lines fill the program image, E lines the expected trace
    task automatic loadStim();
        int              fd;
        int              code;
        int              regNum;
        logic [8*120-1:0] line;
        logic [7:0]      kind;
        logic [31:0]     addr;
        logic [31:0]     value;
        logic [8*16-1:0] name;
        fd = $fopen("tb/socStim.txt", "r");
        if (fd == 0) begin
            $display("Could not open tb/socStim.txt, nothing to run");
            errors++;
            return;
        end
        while (!$feof(fd)) begin
            line = '0;
            kind = 8'h00;
            code = $fgets(line, fd);
            code = $sscanf(line, "%s", kind);
            if (kind == "P" && progCount < 1024) begin
                code = $sscanf(line, "%s %h %h", kind, addr, value);
                progIdx[progCount]  = addr[9:0];
                progWord[progCount] = value;
                progCount++;
            end else if (kind == "E" && expCount < MAX_EXP) begin
                code = $sscanf(line, "%s %s %d %h", kind, name, regNum, value);
                expName[expCount]  = name;
                expReg[expCount]   = regNum[4:0];
                expValue[expCount] = value;
                expCount++;
            end
        end
        $fclose(fd);
        if (expCount == 0) begin
            $display("The stim file holds no expected register writes");
            errors++;
        end
    endtask

    initial begin : mainFlow
        int testErrors;
        rst         = 1'b1;
        progWe      = 1'b0;
        progAddr    = '0;
        progData    = '0;
        progCount   = 0;
        expCount    = 0;
        expIdx      = 0;
        errors      = 0;
        checks      = 0;
        testsPassed = 0;
        testsFailed = 0;
        traceOn     = 1'b0;
        loadStim();

        // Core held in reset while the program is written
        for (int i = 0; i < progCount; i++) begin
            @(posedge clk);
            progWe   <= 1'b1;
            progAddr <= progIdx[i];
            progData <= progWord[i];
        end

        testErrors = errors;
        repeat (RESET_CYCLES) begin
            @(posedge clk);
            progWe <= 1'b0;
            @(negedge clk);
            checkValue("reset", BOOT_PC, PC);
            checkValue("reset", 32'd0, {31'd0, wbEn});
        end
        @(posedge clk);
        rst <= 1'b0;
        // First cycle out of reset
        @(negedge clk);
        checkValue("reset", BOOT_PC, PC);
        checkValue("reset", 32'd0, {31'd0, wbEn});
        reportTest("reset", errors - testErrors);

        // Each writeback pulse is matched against the next E line
        traceOn    = 1'b1;
        testErrors = errors;
        while (expIdx < expCount) begin
            @(negedge clk);
            if (wbEn === 1'b1) begin
                checkValue(expName[expIdx], {27'd0, expReg[expIdx]}, {27'd0, wbAddr});
                checkValue(expName[expIdx], expValue[expIdx], wbData);
                if (expIdx == expCount - 1 || expName[expIdx + 1] != expName[expIdx]) begin
                    reportTest(expName[expIdx], errors - testErrors);
                    testErrors = errors;
                end
                expIdx++;
            end
        end

        $display("Summary: %0d tests passed, %0d tests failed, %0d checks, %0d errors",
                 testsPassed, testsFailed, checks, errors);
        if (errors == 0 && testsFailed == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    // Budget grows with the trace length and the timer delay
    initial begin : watchdog
        int limit;
        wait (traceOn);
        limit = expCount * 8 + TIMER_PRESET + 200;
        repeat (limit) @(posedge clk);
        $display("Timeout after %0d cycles, the program stalled with %0d of %0d writes seen",
                 limit, expIdx, expCount);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

//--- hdl/mipsSoc.sv
`timescale 1ns/100ps

module mipsSoc (
    input  logic        clk,
    input  logic        rst,
    input  logic        progWe,
    input  logic [9:0]  progAddr,
    input  logic [31:0] progData,
    output logic [31:0] PC,
    output logic        wbEn,
    output logic [4:0]  wbAddr,
    output logic [31:0] wbData
);
    // Core to bridge
    logic [31:0] instr, BrAddr, BrWData, BrRData;
    logic [3:0]  BrWE;
    logic        BrReq, BrDone;

    // APB side
    logic [31:0] paddr, pwdata, prdataRam, prdataTimer;
    logic        pwrite, penable, pselRam, pselTimer, preadyRam, preadyTimer;
    logic        timerIrq;

    // Timer sits on HWInt bit 2
    cpu core (
        .clk(clk), .rst(rst), .PC(PC), .Instr(instr),
        .BrAddr(BrAddr), .BrWData(BrWData), .BrWE(BrWE), .BrReq(BrReq),
        .BrRData(BrRData), .BrDone(BrDone), .HWInt({5'b0, timerIrq}),
        .wbEn(wbEn), .wbAddr(wbAddr), .wbData(wbData)
    );

    apbBridge bridge (
        .clk(clk), .rst(rst), .BrAddr(BrAddr), .BrWData(BrWData), .BrWE(BrWE),
        .BrReq(BrReq), .BrRData(BrRData), .BrDone(BrDone),
        .paddr(paddr), .pwdata(pwdata), .pwrite(pwrite), .penable(penable),
        .pselRam(pselRam), .pselTimer(pselTimer),
        .prdataRam(prdataRam), .prdataTimer(prdataTimer),
        .preadyRam(preadyRam), .preadyTimer(preadyTimer)
    );

    apbRam dataRam (
        .clk(clk), .paddr(paddr), .pwdata(pwdata), .pwrite(pwrite),
        .psel(pselRam), .penable(penable), .prdata(prdataRam), .pready(preadyRam)
    );

    apbTimer timer (
        .clk(clk), .rst(rst), .paddr(paddr), .pwdata(pwdata), .pwrite(pwrite),
        .psel(pselTimer), .penable(penable), .prdata(prdataTimer),
        .pready(preadyTimer), .irq(timerIrq)
    );

    progMem imem (
        .clk(clk), .loadWe(progWe), .loadAddr(progAddr), .loadData(progData),
        .fetchAddr(PC), .fetchData(instr)
    );

endmodule

//--- hdl/progMem.sv
`timescale 1ns/100ps

module progMem import mipsPkg::*; (
    input  logic        clk,
    input  logic        loadWe,
    input  logic [9:0]  loadAddr,
    input  logic [31:0] loadData,
    input  logic [31:0] fetchAddr,
    output logic [31:0] fetchData
);
    logic [31:0] mem [PROG_WORDS];
    logic [31:0] offset;

    always_ff @(posedge clk) begin
        if (loadWe)
            mem[loadAddr] <= loadData;
    end

    // Handler at 0x4180 folds onto word 0x60
    assign offset    = fetchAddr - RESET_PC;
    assign fetchData = mem[offset[11:2]];

endmodule

//--- hdl/apbRam.sv
`timescale 1ns/100ps

module apbRam import mipsPkg::*; (
    input  logic        clk,
    input  logic [31:0] paddr,
    input  logic [31:0] pwdata,
    input  logic        pwrite,
    input  logic        psel,
    input  logic        penable,
    output logic [31:0] prdata,
    output logic        pready
);
    logic [31:0]       mem [RAM_WORDS];
    logic [RAM_AW-1:0] wordIdx;

    assign wordIdx = paddr[RAM_AW+1:2];

    // Writes land in the access phase
    always_ff @(posedge clk) begin
        if (psel && penable && pwrite)
            mem[wordIdx] <= pwdata;
    end

    assign prdata = mem[wordIdx];
    assign pready = 1'b1;

endmodule

//--- hdl/apbTimer.sv
`timescale 1ns/100ps

module apbTimer import mipsPkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic [31:0] paddr,
    input  logic [31:0] pwdata,
    input  logic        pwrite,
    input  logic        psel,
    input  logic        penable,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        irq
);
    logic [1:0]  ctrl;
    logic [31:0] preset, count;
    logic [1:0]  regSel;
    logic        wrEn;

    assign regSel = paddr[3:2];
    assign wrEn   = psel && penable && pwrite;
    assign pready = 1'b1;

    always_ff @(posedge clk) begin
        if (rst) begin
            ctrl   <= '0;
            preset <= '0;
            count  <= '0;
            irq    <= 1'b0;
        end else if (wrEn && regSel == TMR_CTRL) begin
            // Any CTRL write acknowledges the interrupt
            ctrl <= pwdata[1:0];
            irq  <= 1'b0;
            if (pwdata[0])
                count <= preset;
        end else begin
            if (wrEn && regSel == TMR_PRESET)
                preset <= pwdata;
            // Count holds once it reaches zero
            if (ctrl[0] && count != '0) begin
                count <= count - 32'd1;
                if (count == 32'd1 && ctrl[1])
                    irq <= 1'b1;
            end
        end
    end

    always_comb begin
        case (regSel)
            TMR_CTRL:   prdata = {30'h0, ctrl};
            TMR_PRESET: prdata = preset;
            TMR_COUNT:  prdata = count;
            default:    prdata = '0;
        endcase
    end

endmodule

//--- hdl/apbBridge.sv
`timescale 1ns/100ps

module apbBridge import mipsPkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic [31:0] BrAddr,
    input  logic [31:0] BrWData,
    input  logic [3:0]  BrWE,
    input  logic        BrReq,
    output logic [31:0] BrRData,
    output logic        BrDone,
    output logic [31:0] paddr,
    output logic [31:0] pwdata,
    output logic        pwrite,
    output logic        penable,
    output logic        pselRam,
    output logic        pselTimer,
    input  logic [31:0] prdataRam,
    input  logic [31:0] prdataTimer,
    input  logic        preadyRam,
    input  logic        preadyTimer
);
    typedef enum logic [1:0] {IDLE, SETUP, ACCESS} apbState_t;

    apbState_t state, stateNext;
    logic selRam, selTimer, readyMux;

    // Region decode, stable while BrReq is held
    assign selTimer = (BrAddr[31:4] == TIMER_BASE[31:4]);
    assign selRam   = !selTimer && ((BrAddr - RAM_BASE) < RAM_BYTES);

    // Unmapped addresses complete at once and read zero
    assign readyMux = selTimer ? preadyTimer : (selRam ? preadyRam : 1'b1);

    always_ff @(posedge clk) begin
        if (rst)
            state <= IDLE;
        else
            state <= stateNext;
    end

    always_comb begin
        case (state)
            IDLE:    stateNext = BrReq ? SETUP : IDLE;
            SETUP:   stateNext = ACCESS;
            ACCESS:  stateNext = readyMux ? IDLE : ACCESS;
            default: stateNext = IDLE;
        endcase
    end

    assign paddr     = BrAddr;
    assign pwdata    = BrWData;
    assign pwrite    = |BrWE;
    assign pselRam   = selRam && (state != IDLE);
    assign pselTimer = selTimer && (state != IDLE);
    assign penable   = (state == ACCESS) && (selRam || selTimer);
    assign BrDone    = (state == ACCESS) && readyMux;
    assign BrRData   = selTimer ? prdataTimer : (selRam ? prdataRam : '0);

    assert property (@(posedge clk) disable iff (rst)
        $rose(penable) |-> $past(pselRam || pselTimer) && (pselRam || pselTimer))
        else $error("apbBridge: penable without a setup phase");

endmodule

//--- cpu/cpu.sv
`timescale 1ns/100ps

module cpu import mipsPkg::*; (
    input  logic        clk,
    input  logic        rst,
    output logic [31:0] PC,
    input  logic [31:0] Instr,
    output logic [31:0] BrAddr,
    output logic [31:0] BrWData,
    output logic [3:0]  BrWE,
    output logic        BrReq,
    input  logic [31:0] BrRData,
    input  logic        BrDone,
    input  logic [7:2]  HWInt,
    output logic        wbEn,
    output logic [4:0]  wbAddr,
    output logic [31:0] wbData
);
    cpuState_t   state;
    aluOp_t      aluOp;
    logic        irWrite, pcWrite, regWrite, regDstRt, memToReg, memWrite;
    logic        takeIrq, doEret, inHandler, regEqual, zeroExt;
    logic [1:0]  pcSel;
    logic [31:0] instrReg, regA, regB, aluOut, memData, epc;
    logic [31:0] rdata1, rdata2, immExt, aluB, aluResult, nextPc;

    // Instruction fields
    logic [5:0]  opcode, funct;
    logic [4:0]  rs, rt, rd;
    logic [15:0] imm16;
    logic [25:0] jumpIdx;

    assign opcode  = instrReg[31:26];
    assign rs      = instrReg[25:21];
    assign rt      = instrReg[20:16];
    assign rd      = instrReg[15:11];
    assign funct   = instrReg[5:0];
    assign imm16   = instrReg[15:0];
    assign jumpIdx = instrReg[25:0];

    cpuCtrl ctrl (
        .clk(clk), .rst(rst), .opcode(opcode), .funct(funct),
        .regEqual(regEqual), .irqPending(|HWInt), .inHandler(inHandler), .BrDone(BrDone),
        .state(state), .aluOp(aluOp), .irWrite(irWrite), .pcWrite(pcWrite), .pcSel(pcSel),
        .regWrite(regWrite), .regDstRt(regDstRt), .memToReg(memToReg), .memWrite(memWrite),
        .BrReq(BrReq), .takeIrq(takeIrq), .doEret(doEret)
    );

    grf regFile (
        .clk(clk), .rst(rst), .raddr1(rs), .raddr2(rt), .rdata1(rdata1), .rdata2(rdata2),
        .we(wbEn), .waddr(wbAddr), .wdata(wbData)
    );

    // ori and lui take the immediate unsigned
    assign zeroExt  = (opcode == OP_ORI) || (opcode == OP_LUI);
    assign immExt   = zeroExt ? {16'h0, imm16} : {{16{imm16[15]}}, imm16};
    assign aluB     = (opcode == OP_RTYPE) ? regB : immExt;
    assign regEqual = (regA == regB);

    always_comb begin
        case (aluOp)
            SUB:     aluResult = regA - aluB;
            OR:      aluResult = regA | aluB;
            LUI:     aluResult = {aluB[15:0], 16'h0};
            default: aluResult = regA + aluB;
        endcase
    end

    // PC already points past the instruction in EXEC
    always_comb begin
        case (pcSel)
            PCSEL_BRANCH: nextPc = PC + {immExt[29:0], 2'b00};
            PCSEL_JUMP:   nextPc = {PC[31:28], jumpIdx, 2'b00};
            PCSEL_EPC:    nextPc = epc;
            default:      nextPc = PC + 32'd4;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            PC        <= RESET_PC;
            inHandler <= 1'b0;
        end else if (takeIrq) begin
            PC        <= HANDLER_PC;
            inHandler <= 1'b1;
        end else begin
            if (pcWrite)
                PC <= nextPc;
            if (doEret)
                inHandler <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (irWrite)
            instrReg <= Instr;
        if (takeIrq)
            epc <= PC;
        if (state == DECODE) begin
            regA <= rdata1;
            regB <= rdata2;
        end
        if (state == EXEC)
            aluOut <= aluResult;
        if (state == MEM && BrDone)
            memData <= BrRData;
    end

    // Bridge side and writeback trace
    assign BrAddr  = aluOut;
    assign BrWData = regB;
    assign BrWE    = memWrite ? 4'hf : 4'h0;
    assign wbEn    = regWrite;
    assign wbAddr  = regDstRt ? rt : rd;
    assign wbData  = memToReg ? memData : aluOut;

    assert property (@(posedge clk) disable iff (rst) (BrWE != 4'h0) |-> BrReq)
        else $error("cpu: store enable outside a bus request");

    // Request must hold steady until the bridge completes it
    assert property (@(posedge clk) disable iff (rst)
        BrReq && !BrDone |=> BrReq && $stable(BrAddr) && $stable(BrWData) && $stable(BrWE))
        else $error("cpu: bus request changed before BrDone");

endmodule

//--- cpu/cpuCtrl.sv
`timescale 1ns/100ps

module cpuCtrl import mipsPkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic [5:0] opcode,
    input  logic [5:0] funct,
    input  logic       regEqual,
    input  logic       irqPending,
    input  logic       inHandler,
    input  logic       BrDone,
    output cpuState_t  state,
    output aluOp_t     aluOp,
    output logic       irWrite,
    output logic       pcWrite,
    output logic [1:0] pcSel,
    output logic       regWrite,
    output logic       regDstRt,
    output logic       memToReg,
    output logic       memWrite,
    output logic       BrReq,
    output logic       takeIrq,
    output logic       doEret
);
    cpuState_t stateNext;
    logic isAddu, isSubu, isOri, isLui, isLw, isSw, isBeq, isJ, isEret;
    logic irqEnter;

    assign isAddu   = (opcode == OP_RTYPE) && (funct == FN_ADDU);
    assign isSubu   = (opcode == OP_RTYPE) && (funct == FN_SUBU);
    assign isOri    = (opcode == OP_ORI);
    assign isLui    = (opcode == OP_LUI);
    assign isLw     = (opcode == OP_LW);
    assign isSw     = (opcode == OP_SW);
    assign isBeq    = (opcode == OP_BEQ);
    assign isJ      = (opcode == OP_J);
    assign isEret   = (opcode == OP_COP0) && (funct == FN_ERET);
    assign irqEnter = irqPending && !inHandler;

    always_ff @(posedge clk) begin
        if (rst)
            state <= FETCH;
        else
            state <= stateNext;
    end

    always_comb begin
        case (state)
            FETCH:   stateNext = irqEnter ? IRQ : DECODE;
            DECODE:  stateNext = EXEC;
            EXEC: begin
                if (isLw || isSw)
                    stateNext = MEM;
                else if (isAddu || isSubu || isOri || isLui)
                    stateNext = WB;
                else
                    stateNext = FETCH;
            end
            MEM:     stateNext = BrDone ? (isLw ? WB : FETCH) : MEM;
            default: stateNext = FETCH;
        endcase
    end

    always_comb begin
        irWrite  = (state == FETCH) && !irqEnter;
        pcWrite  = irWrite;
        pcSel    = PCSEL_SEQ;
        takeIrq  = (state == IRQ);
        doEret   = (state == EXEC) && isEret;
        BrReq    = (state == MEM);
        memWrite = BrReq && isSw;
        regWrite = (state == WB);
        regDstRt = isOri || isLui || isLw;
        memToReg = isLw;
        if (state == EXEC) begin
            if (isBeq && regEqual) begin
                pcWrite = 1'b1;
                pcSel   = PCSEL_BRANCH;
            end else if (isJ) begin
                pcWrite = 1'b1;
                pcSel   = PCSEL_JUMP;
            end else if (isEret) begin
                pcWrite = 1'b1;
                pcSel   = PCSEL_EPC;
            end
        end
    end

    // Loads and stores compute their address with ADD
    assign aluOp = isSubu ? SUB : (isOri ? OR : (isLui ? LUI : ADD));

    assert property (@(posedge clk) disable iff (rst)
        state inside {FETCH, DECODE, EXEC, MEM, WB, IRQ})
        else $error("cpuCtrl: illegal state encoding");

endmodule

//--- cpu/grf.sv
`timescale 1ns/100ps

module grf (
    input  logic        clk,
    input  logic        rst,
    input  logic [4:0]  raddr1,
    input  logic [4:0]  raddr2,
    output logic [31:0] rdata1,
    output logic [31:0] rdata2,
    input  logic        we,
    input  logic [4:0]  waddr,
    input  logic [31:0] wdata
);
    logic [31:0] regs [32];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != 5'd0) begin
            regs[waddr] <= wdata;
        end
    end

    // $zero reads as zero
    assign rdata1 = (raddr1 == 5'd0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? '0 : regs[raddr2];

endmodule

//--- common/mipsPkg.sv
package mipsPkg;

    // Primary opcodes
    localparam logic [5:0] OP_RTYPE = 6'h00;
    localparam logic [5:0] OP_J     = 6'h02;
    localparam logic [5:0] OP_BEQ   = 6'h04;
    localparam logic [5:0] OP_ORI   = 6'h0d;
    localparam logic [5:0] OP_LUI   = 6'h0f;
    localparam logic [5:0] OP_COP0  = 6'h10;
    localparam logic [5:0] OP_LW    = 6'h23;
    localparam logic [5:0] OP_SW    = 6'h2b;

    // Function field values
    localparam logic [5:0] FN_ERET = 6'h18;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;

    // Fixed vectors
    localparam logic [31:0] RESET_PC   = 32'h0000_3000;
    localparam logic [31:0] HANDLER_PC = 32'h0000_4180;

    // Address map
    localparam logic [31:0] RAM_BASE   = 32'h0000_0000;
    localparam int          RAM_WORDS  = 1024;
    localparam int          RAM_AW     = $clog2(RAM_WORDS);
    localparam logic [31:0] RAM_BYTES  = RAM_WORDS * 4;
    localparam logic [31:0] TIMER_BASE = 32'h0000_7f00;
    localparam int          PROG_WORDS = 1024;

    // Timer register word offsets
    localparam logic [1:0] TMR_CTRL   = 2'd0;
    localparam logic [1:0] TMR_PRESET = 2'd1;
    localparam logic [1:0] TMR_COUNT  = 2'd2;

    // Next-PC source
    localparam logic [1:0] PCSEL_SEQ    = 2'd0;
    localparam logic [1:0] PCSEL_BRANCH = 2'd1;
    localparam logic [1:0] PCSEL_JUMP   = 2'd2;
    localparam logic [1:0] PCSEL_EPC    = 2'd3;

    typedef enum logic [2:0] {
        FETCH, DECODE, EXEC, MEM, WB, IRQ
    } cpuState_t;

    typedef enum logic [1:0] {
        ADD, SUB, OR, LUI
    } aluOp_t;

endpackage
